/* src/rrx_dse_pkg.sv */
// ---------------------------------------------------------------------
// Shared widths, command-word layout and enums of the stream engine.
// Header word is opcode[31:28], count[27:16], address[15:0]; only the
// low MEM_ADDR_WIDTH address bits reach the internal memory.
// ---------------------------------------------------------------------
package rrx_dse_pkg;

    localparam int CMD_WIDTH      = 32;
    localparam int OP_WIDTH       = 4;
    localparam int COUNT_WIDTH    = 12;
    localparam int MEM_ADDR_WIDTH = 10;
    localparam int MEM_DEPTH      = 1024;

    // Field positions inside a header word
    localparam int OP_LSB    = CMD_WIDTH - OP_WIDTH;
    localparam int COUNT_LSB = OP_LSB - COUNT_WIDTH;

    typedef logic [CMD_WIDTH-1:0]      cmd_word_t;
    typedef logic [COUNT_WIDTH-1:0]    word_count_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP    = 4'd0,
        OP_STREAM = 4'd1,
        OP_STORE  = 4'd2,
        OP_LOAD   = 4'd3
    } dse_op_t;

    typedef enum logic [1:0] {
        ST_HEADER,
        ST_PAYLOAD,
        ST_LOAD_WAIT
    } decoder_state_t;

    // Codes without a defined meaning are treated as NOP
    function automatic dse_op_t decode_op(input logic [OP_WIDTH-1:0] code);
        case (code)
            OP_STREAM: decode_op = OP_STREAM;
            OP_STORE:  decode_op = OP_STORE;
            OP_LOAD:   decode_op = OP_LOAD;
            default:   decode_op = OP_NOP;
        endcase
    endfunction

endpackage

/* src/cmd_header_decoder.sv */
// ---------------------------------------------------------------------
// Splits the command stream into headers and payload words.
// Framing comes only from the header count; tlast is not looked at.
// The input is blocked while a load burst runs.
// ---------------------------------------------------------------------
module cmd_header_decoder
    import rrx_dse_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  logic        s_cmd_axis_tvalid,
    input  cmd_word_t   s_cmd_axis_tdata,
    output logic        s_cmd_axis_tready,
    output logic        pay_valid,
    output logic        pay_last,
    output cmd_word_t   pay_data,
    output dse_op_t     pay_op,
    input  logic        pay_ready,
    output logic        store_start,
    output mem_addr_t   store_base,
    output logic        load_start,
    output mem_addr_t   load_addr,
    output word_count_t load_count,
    input  logic        load_done
);

    decoder_state_t state;
    dse_op_t        hdr_op;
    word_count_t    hdr_count;
    mem_addr_t      hdr_addr;
    dse_op_t        cur_op;
    word_count_t    remaining;
    logic           hdr_fire;
    logic           pay_fire;

    assign hdr_op    = decode_op(s_cmd_axis_tdata[OP_LSB +: OP_WIDTH]);
    assign hdr_count = s_cmd_axis_tdata[COUNT_LSB +: COUNT_WIDTH];
    assign hdr_addr  = s_cmd_axis_tdata[MEM_ADDR_WIDTH-1:0];

    always_comb
    begin
        case (state)
            ST_HEADER:  s_cmd_axis_tready = 1'b1;
            ST_PAYLOAD: s_cmd_axis_tready = pay_ready;
            default:    s_cmd_axis_tready = 1'b0;
        endcase
    end

    assign hdr_fire  = (state == ST_HEADER) && s_cmd_axis_tvalid;
    assign pay_valid = (state == ST_PAYLOAD) && s_cmd_axis_tvalid;
    assign pay_fire  = pay_valid && pay_ready;
    assign pay_data  = s_cmd_axis_tdata;
    assign pay_op    = cur_op;
    assign pay_last  = (remaining == word_count_t'(1));

    // The router latches the write address together with the header
    assign store_start = hdr_fire && (hdr_op == OP_STORE) && (hdr_count != '0);
    assign store_base  = hdr_addr;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state      <= ST_HEADER;
            cur_op     <= OP_NOP;
            remaining  <= '0;
            load_start <= 1'b0;
        end
        else
        begin
            load_start <= 1'b0;
            case (state)
                ST_HEADER:
                begin
                    if (hdr_fire && (hdr_count != '0))
                    begin
                        cur_op    <= hdr_op;
                        remaining <= hdr_count;
                        if (hdr_op == OP_LOAD)
                        begin
                            state      <= ST_LOAD_WAIT;
                            load_start <= 1'b1;
                        end
                        else
                        begin
                            state <= ST_PAYLOAD;
                        end
                    end
                end
                ST_PAYLOAD:
                begin
                    if (pay_fire)
                    begin
                        remaining <= remaining - word_count_t'(1);
                        if (pay_last)
                            state <= ST_HEADER;
                    end
                end
                ST_LOAD_WAIT:
                begin
                    if (load_done)
                        state <= ST_HEADER;
                end
                default:
                    state <= ST_HEADER;
            endcase
        end
    end

    // Burst parameters are only sampled by the streamer on load_start
    always_ff @(posedge aclk)
    begin
        if (hdr_fire)
        begin
            load_addr  <= hdr_addr;
            load_count <= hdr_count;
        end
    end

    // A load pulse belongs to the first cycle of the load wait
    assert property (@(posedge aclk) disable iff (reset)
        load_start |-> (state == ST_LOAD_WAIT) && ($past(state) == ST_HEADER));

endmodule

/* src/payload_router.sv */
// ---------------------------------------------------------------------
// Sends stream payload to a one-word render output register and
// store payload to the memory write port. Stores never stall.
// ---------------------------------------------------------------------
module payload_router
    import rrx_dse_pkg::*;
(
    input  logic      aclk,
    input  logic      reset,
    input  logic      pay_valid,
    input  logic      pay_last,
    input  cmd_word_t pay_data,
    input  dse_op_t   pay_op,
    input  logic      store_start,
    input  mem_addr_t store_base,
    output logic      pay_ready,
    output logic      wr_en,
    output mem_addr_t wr_addr,
    output cmd_word_t wr_data,
    output logic      m_render_axis_tvalid,
    output logic      m_render_axis_tlast,
    output cmd_word_t m_render_axis_tdata,
    input  logic      m_render_axis_tready
);

    logic render_free;
    logic render_load;

    // The register may refill in the same cycle its word is taken
    assign render_free = !m_render_axis_tvalid || m_render_axis_tready;
    assign pay_ready   = (pay_op == OP_STREAM) ? render_free : 1'b1;
    assign render_load = pay_valid && (pay_op == OP_STREAM) && render_free;

    assign wr_en   = pay_valid && (pay_op == OP_STORE);
    assign wr_data = pay_data;

    always_ff @(posedge aclk)
    begin
        if (reset)
            m_render_axis_tvalid <= 1'b0;
        else if (render_load)
            m_render_axis_tvalid <= 1'b1;
        else if (m_render_axis_tready)
            m_render_axis_tvalid <= 1'b0;
    end

    always_ff @(posedge aclk)
    begin
        if (render_load)
        begin
            m_render_axis_tdata <= pay_data;
            m_render_axis_tlast <= pay_last;
        end
    end

    // Write address starts at the header base and steps per stored word
    always_ff @(posedge aclk)
    begin
        if (reset)
            wr_addr <= '0;
        else if (store_start)
            wr_addr <= store_base;
        else if (wr_en)
            wr_addr <= wr_addr + mem_addr_t'(1);
    end

    assert property (@(posedge aclk) disable iff (reset)
        m_render_axis_tvalid && !m_render_axis_tready
        |=> m_render_axis_tvalid && $stable(m_render_axis_tdata));

endmodule

/* src/stream_buffer_ram.sv */
// ---------------------------------------------------------------------
// Word memory with one write and one registered read port.
// Read data is valid one cycle after rd_en. A read and a write to the
// same address in one cycle return the old word.
// ---------------------------------------------------------------------
module stream_buffer_ram
    import rrx_dse_pkg::*;
(
    input  logic      aclk,
    input  logic      wr_en,
    input  mem_addr_t wr_addr,
    input  cmd_word_t wr_data,
    input  logic      rd_en,
    input  mem_addr_t rd_addr,
    output cmd_word_t rd_data
);

    cmd_word_t mem [MEM_DEPTH];

    always_ff @(posedge aclk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Output holds its last value while no read is issued
    always_ff @(posedge aclk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

/* src/load_streamer.sv */
// ---------------------------------------------------------------------
// Reads a burst from the word memory and plays it out as a stream.
// A two-entry buffer absorbs the one-cycle read latency so the
// output can run one word per cycle under back-pressure.
// ---------------------------------------------------------------------
module load_streamer
    import rrx_dse_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  logic        load_start,
    input  mem_addr_t   load_addr,
    input  word_count_t load_count,
    output logic        rd_en,
    output mem_addr_t   rd_addr,
    input  cmd_word_t   rd_data,
    output logic        load_done,
    output logic        m_framebuffer_axis_tvalid,
    output logic        m_framebuffer_axis_tlast,
    output cmd_word_t   m_framebuffer_axis_tdata,
    input  logic        m_framebuffer_axis_tready
);

    word_count_t rd_remaining;
    logic        rd_pending;
    logic        rd_pending_last;
    cmd_word_t   buf_data [2];
    logic        buf_last [2];
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  buf_count;
    logic        push;
    logic        pop;
    logic [1:0]  count_after;

    assign push = rd_pending;
    assign pop  = m_framebuffer_axis_tvalid && m_framebuffer_axis_tready;

    // Entries held after this edge; a new read needs one free slot then
    assign count_after = buf_count + 2'(push) - 2'(pop);
    assign rd_en       = (rd_remaining != '0) && (count_after <= 2'd1);

    assign m_framebuffer_axis_tvalid = (buf_count != 2'd0);
    assign m_framebuffer_axis_tdata  = buf_data[rd_ptr];
    assign m_framebuffer_axis_tlast  = buf_last[rd_ptr];

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            rd_remaining    <= '0;
            rd_addr         <= '0;
            rd_pending      <= 1'b0;
            rd_pending_last <= 1'b0;
            wr_ptr          <= 1'b0;
            rd_ptr          <= 1'b0;
            buf_count       <= 2'd0;
            load_done       <= 1'b0;
        end
        else
        begin
            if (load_start)
            begin
                rd_remaining <= load_count;
                rd_addr      <= load_addr;
            end
            else if (rd_en)
            begin
                rd_remaining <= rd_remaining - word_count_t'(1);
                rd_addr      <= rd_addr + mem_addr_t'(1);
            end
            rd_pending      <= rd_en;
            rd_pending_last <= rd_en && (rd_remaining == word_count_t'(1));
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            buf_count <= count_after;
            load_done <= pop && m_framebuffer_axis_tlast;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            buf_data[wr_ptr] <= rd_data;
            buf_last[wr_ptr] <= rd_pending_last;
        end
    end

    // The word returned by a read must find a free slot
    assert property (@(posedge aclk) disable iff (reset)
        rd_en |=> (buf_count != 2'd2) || pop);

endmodule

/* src/rrx_dse_top.sv */
// ---------------------------------------------------------------------
// Command-stream engine: decoder, payload router, word memory and
// load streamer in a chain. s_cmd_axis_tlast is accepted but unused
// because framing comes from the header counts.
// ---------------------------------------------------------------------
module rrx_dse_top
    import rrx_dse_pkg::*;
(
    input  logic      aclk,
    input  logic      reset,
    input  logic      s_cmd_axis_tvalid,
    input  logic      s_cmd_axis_tlast,
    input  cmd_word_t s_cmd_axis_tdata,
    output logic      s_cmd_axis_tready,
    output logic      m_render_axis_tvalid,
    output logic      m_render_axis_tlast,
    output cmd_word_t m_render_axis_tdata,
    input  logic      m_render_axis_tready,
    output logic      m_framebuffer_axis_tvalid,
    output logic      m_framebuffer_axis_tlast,
    output cmd_word_t m_framebuffer_axis_tdata,
    input  logic      m_framebuffer_axis_tready
);

    logic        pay_valid;
    logic        pay_last;
    logic        pay_ready;
    cmd_word_t   pay_data;
    dse_op_t     pay_op;
    logic        store_start;
    mem_addr_t   store_base;
    logic        load_start;
    mem_addr_t   load_addr;
    word_count_t load_count;
    logic        load_done;
    logic        wr_en;
    mem_addr_t   wr_addr;
    cmd_word_t   wr_data;
    logic        rd_en;
    mem_addr_t   rd_addr;
    cmd_word_t   rd_data;

    cmd_header_decoder decoder (
        .aclk, .reset,
        .s_cmd_axis_tvalid, .s_cmd_axis_tdata, .s_cmd_axis_tready,
        .pay_valid, .pay_last, .pay_data, .pay_op, .pay_ready,
        .store_start, .store_base,
        .load_start, .load_addr, .load_count, .load_done
    );

    payload_router router (
        .aclk, .reset,
        .pay_valid, .pay_last, .pay_data, .pay_op,
        .store_start, .store_base, .pay_ready,
        .wr_en, .wr_addr, .wr_data,
        .m_render_axis_tvalid, .m_render_axis_tlast,
        .m_render_axis_tdata, .m_render_axis_tready
    );

    stream_buffer_ram ram (
        .aclk, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
    );

    load_streamer streamer (
        .aclk, .reset,
        .load_start, .load_addr, .load_count,
        .rd_en, .rd_addr, .rd_data, .load_done,
        .m_framebuffer_axis_tvalid, .m_framebuffer_axis_tlast,
        .m_framebuffer_axis_tdata, .m_framebuffer_axis_tready
    );

endmodule

/* tb/tb_rrx_dse.sv */
// ----------------------------------------------------------------------
// Testbench for the command-stream engine. Command words and expected
// output words come from tb/dse_golden.txt, read relative to the project
// root. Both output tready lines toggle randomly from a fixed seed.
// ----------------------------------------------------------------------
module tb_rrx_dse
    import rrx_dse_pkg::*;
();

    localparam int MAX_LINES = 64;

    logic        aclk;
    logic        reset;
    logic        s_cmd_axis_tvalid;
    logic        s_cmd_axis_tlast;
    cmd_word_t   s_cmd_axis_tdata;
    logic        s_cmd_axis_tready;
    logic        m_render_axis_tvalid;
    logic        m_render_axis_tlast;
    cmd_word_t   m_render_axis_tdata;
    logic        m_render_axis_tready;
    logic        m_framebuffer_axis_tvalid;
    logic        m_framebuffer_axis_tlast;
    cmd_word_t   m_framebuffer_axis_tdata;
    logic        m_framebuffer_axis_tready;

    // Three entries per golden line: kind, data word, last flag
    logic [31:0] golden_raw [0:3*MAX_LINES-1];
    cmd_word_t   cmd_data [$];
    logic        cmd_last [$];
    cmd_word_t   render_data [$];
    logic        render_last [$];
    cmd_word_t   fb_data [$];
    logic        fb_last [$];
    int          line_count;
    logic        golden_loaded;
    integer      seed;

    rrx_dse_top UUT (
        .aclk                      (aclk),
        .reset                     (reset),
        .s_cmd_axis_tvalid         (s_cmd_axis_tvalid),
        .s_cmd_axis_tlast          (s_cmd_axis_tlast),
        .s_cmd_axis_tdata          (s_cmd_axis_tdata),
        .s_cmd_axis_tready         (s_cmd_axis_tready),
        .m_render_axis_tvalid      (m_render_axis_tvalid),
        .m_render_axis_tlast       (m_render_axis_tlast),
        .m_render_axis_tdata       (m_render_axis_tdata),
        .m_render_axis_tready      (m_render_axis_tready),
        .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
        .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata),
        .m_framebuffer_axis_tready (m_framebuffer_axis_tready)
    );

    always #20 aclk = !aclk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input cmd_word_t expected,
                                   input cmd_word_t actual);
        stop_with_failure($sformatf("FAILED at time %0t: %s expected %h actual %h",
                                    $time, name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            report_mismatch(name, cmd_word_t'(expected), cmd_word_t'(actual));
    endtask

    task automatic check_render_word(input cmd_word_t data, input logic last);
        cmd_word_t exp_data;
        logic      exp_last;
        if (render_data.size() == 0)
            stop_with_failure("render output sent a word that was not expected");
        else
        begin
            exp_data = render_data.pop_front();
            exp_last = render_last.pop_front();
            if (data !== exp_data)
                report_mismatch("m_render_axis_tdata", exp_data, data);
            else if (last !== exp_last)
                report_mismatch("m_render_axis_tlast", cmd_word_t'(exp_last),
                                cmd_word_t'(last));
        end
    endtask

    task automatic check_framebuffer_word(input cmd_word_t data, input logic last);
        cmd_word_t exp_data;
        logic      exp_last;
        if (fb_data.size() == 0)
            stop_with_failure("framebuffer output sent a word that was not expected");
        else
        begin
            exp_data = fb_data.pop_front();
            exp_last = fb_last.pop_front();
            if (data !== exp_data)
                report_mismatch("m_framebuffer_axis_tdata", exp_data, data);
            else if (last !== exp_last)
                report_mismatch("m_framebuffer_axis_tlast", cmd_word_t'(exp_last),
                                cmd_word_t'(last));
        end
    endtask

    // Unloaded entries stay unknown, which marks the end of the file
    task automatic load_golden;
        int          idx;
        logic [31:0] kind;
        line_count = 0;
        $readmemh("tb/dse_golden.txt", golden_raw);
        for (idx = 0; idx < MAX_LINES; idx++)
        begin
            kind = golden_raw[3*idx];
            if (!$isunknown(kind))
            begin
                line_count++;
                case (kind)
                    32'd0:
                    begin
                        cmd_data.push_back(golden_raw[3*idx+1]);
                        cmd_last.push_back(golden_raw[3*idx+2][0]);
                    end
                    32'd1:
                    begin
                        render_data.push_back(golden_raw[3*idx+1]);
                        render_last.push_back(golden_raw[3*idx+2][0]);
                    end
                    32'd2:
                    begin
                        fb_data.push_back(golden_raw[3*idx+1]);
                        fb_last.push_back(golden_raw[3*idx+2][0]);
                    end
                    default:
                        stop_with_failure("golden file holds an unknown kind tag");
                endcase
            end
        end
        if (line_count == 0)
            stop_with_failure("golden file is missing or holds no lines");
    endtask

    // Each word is held from a falling edge until a rising edge accepts it
    task automatic drive_commands;
        int i;
        for (i = 0; i < cmd_data.size(); i++)
        begin
            @(negedge aclk);
            s_cmd_axis_tvalid = 1'b1;
            s_cmd_axis_tdata  = cmd_data[i];
            s_cmd_axis_tlast  = cmd_last[i];
            do
                @(posedge aclk);
            while (!s_cmd_axis_tready);
        end
        @(negedge aclk);
        s_cmd_axis_tvalid = 1'b0;
        s_cmd_axis_tlast  = 1'b0;
    endtask

    always @(negedge aclk)
    begin
        m_render_axis_tready      = ($random(seed) & 3) != 0;
        m_framebuffer_axis_tready = ($random(seed) & 1) != 0;
    end

    // Handshakes are taken from the values held just before the rising edge
    always @(posedge aclk)
    begin
        if (!reset && m_render_axis_tvalid && m_render_axis_tready)
            check_render_word(m_render_axis_tdata, m_render_axis_tlast);
    end

    always @(posedge aclk)
    begin
        if (!reset && m_framebuffer_axis_tvalid && m_framebuffer_axis_tready)
            check_framebuffer_word(m_framebuffer_axis_tdata, m_framebuffer_axis_tlast);
    end

    initial
    begin
        wait (golden_loaded === 1'b1);
        repeat (line_count * 20 + 200) @(posedge aclk);
        stop_with_failure("timeout: outputs still missing");
    end

    initial
    begin
        aclk                      = 1'b0;
        reset                     = 1'b1;
        s_cmd_axis_tvalid         = 1'b0;
        s_cmd_axis_tlast          = 1'b0;
        s_cmd_axis_tdata          = '0;
        m_render_axis_tready      = 1'b0;
        m_framebuffer_axis_tready = 1'b0;
        seed                      = 81;
        golden_loaded             = 1'b0;
        load_golden();
        golden_loaded = 1'b1;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        check_flag("s_cmd_axis_tready", 1'b1, s_cmd_axis_tready);
        check_flag("m_render_axis_tvalid", 1'b0, m_render_axis_tvalid);
        check_flag("m_framebuffer_axis_tvalid", 1'b0, m_framebuffer_axis_tvalid);
        drive_commands();
        while ((render_data.size() != 0) || (fb_data.size() != 0))
            @(posedge aclk);
        // A few more cycles so that a surplus word would still be caught
        repeat (20) @(posedge aclk);
        // With every command done the engine is idle again
        if ((s_cmd_axis_tready === 1'b1) && (m_render_axis_tvalid === 1'b0)
            && (m_framebuffer_axis_tvalid === 1'b0))
        begin
            $display(">>> PASS");
            $finish;
        end
        else
            stop_with_failure("engine still busy after the last expected word");
    end

endmodule

/* tb/dse_golden.txt */
// Columns (hex): kind, data word, last flag. Kind 0 is a command word for the
// input, kind 1 an expected render word, kind 2 an expected framebuffer word
0 10030000 0
0 aaaa0001 0
0 aaaa0002 0
0 aaaa0003 1
1 aaaa0001 0
1 aaaa0002 0
1 aaaa0003 1
0 20040010 0
0 c0de0010 0
0 c0de0011 0
0 c0de0012 0
0 c0de0013 1
0 00000005 1
0 70010000 0
0 12345678 1
0 f0000000 1
0 10000000 1
0 30040010 1
2 c0de0010 0
2 c0de0011 0
2 c0de0012 0
2 c0de0013 1
0 30020012 1
2 c0de0012 0
2 c0de0013 1
0 30000010 1
0 10020000 0
0 beef0001 0
0 beef0002 1
1 beef0001 0
1 beef0002 1

/* list.f */
src/rrx_dse_pkg.sv
src/cmd_header_decoder.sv
src/payload_router.sv
src/stream_buffer_ram.sv
src/load_streamer.sv
src/rrx_dse_top.sv
tb/tb_rrx_dse.sv

/* Bender.yml */
package:
  name: rrx_dse

sources:
  - src/rrx_dse_pkg.sv
  - src/cmd_header_decoder.sv
  - src/payload_router.sv
  - src/stream_buffer_ram.sv
  - src/load_streamer.sv
  - src/rrx_dse_top.sv
  - target: test
    files:
      - tb/tb_rrx_dse.sv
